/* logic/io_pkg.sv */
`default_nettype none

package io_pkg;

    // ----------------------------------------------------------
    // widths with a meaning
    // ----------------------------------------------------------
    typedef logic [15:0] io_addr_t;   // port address, byte granular
    typedef logic [31:0] io_data_t;   // core word and bus word
    typedef logic [3:0]  io_be_t;     // one enable per byte lane
    typedef logic [2:0]  io_len_t;    // 1, 2 or 4 bytes

    // control FSM
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WRITE_1,
        ST_WRITE_2,
        ST_READ_1,
        ST_READ_2
    } io_state_t;

    // ----------------------------------------------------------
    // port map, windows are [lo, hi)
    // ----------------------------------------------------------
    localparam int PORT_RANGE_COUNT = 11;

    localparam io_addr_t PORT_RANGE_LO [PORT_RANGE_COUNT] = '{
        16'h0000, 16'h0040, 16'h0060, 16'h0080, 16'h00C0, 16'h01F0,
        16'h0220, 16'h0388, 16'h03B0, 16'h03F0, 16'h8888};

    localparam io_addr_t PORT_RANGE_HI [PORT_RANGE_COUNT] = '{
        16'h0010, 16'h0044, 16'h0068, 16'h00A0, 16'h00E0, 16'h01F8,
        16'h0230, 16'h038C, 16'h03E0, 16'h03F8, 16'h8890};

    // words where only the low 16 bits exist
    localparam int HALF_COUNT = 3;
    localparam io_addr_t HALF_PORTS [HALF_COUNT] = '{16'h0020, 16'h0070, 16'h00A0};

    localparam io_data_t IO_ONES = 32'hFFFF_FFFF;   // floating bus reads back high

endpackage

`default_nettype wire

/* logic/io_lane_split.sv */
`timescale 1ns/10ps
`default_nettype none

module io_lane_split (
    input  wire io_pkg::io_addr_t req_address,
    input  wire io_pkg::io_len_t  req_length,
    input  wire io_pkg::io_data_t write_data,

    output io_pkg::io_be_t   be_first,      // lanes of the lower word
    output io_pkg::io_be_t   be_second,     // spill-over lanes, next word up
    output io_pkg::io_data_t data_first,
    output io_pkg::io_data_t data_second,
    output logic             two_phase
);

    logic [1:0]  offset;      // byte offset inside the word
    logic [3:0]  base_mask;   // lanes as if the access were aligned
    logic [7:0]  lane_mask;   // lanes over two adjacent words
    logic [63:0] data_wide;   // write data placed over two words

    assign offset = req_address[1:0];

    // ----------------------------------------------------------
    // lane mask from the length
    // ----------------------------------------------------------
    always_comb begin
        case (req_length)
            3'd1:    base_mask = 4'b0001;
            3'd2:    base_mask = 4'b0011;
            default: base_mask = 4'b1111;   // 4 bytes, other codes not issued
        endcase
    end

    // slide the mask up by the offset, upper nibble is the second word
    assign lane_mask = {4'b0000, base_mask} << offset;

    assign be_first  = lane_mask[3:0];
    assign be_second = lane_mask[7:4];   // zero when nothing spills

    // ----------------------------------------------------------
    // write data
    // ----------------------------------------------------------
    // byte 0 of the request lands on lane 'offset'
    assign data_wide = {32'd0, write_data} << {offset, 3'b000};

    assign data_first  = data_wide[31:0];
    assign data_second = data_wide[63:32];   // leftover bytes at the bottom

    // crossing a word boundary
    //   2 bytes only from offset 3
    //   4 bytes from any nonzero offset
    assign two_phase = (req_length == 3'd2 && offset == 2'd3) ||
                       (req_length == 3'd4 && offset != 2'd0);

endmodule

`default_nettype wire

/* logic/io_port_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module io_port_decode (
    input  wire io_pkg::io_addr_t bus_address,      // word aligned
    input  wire io_pkg::io_be_t   bus_byteenable,
    input  wire io_pkg::io_data_t bus_readdata,

    output logic             unmapped,
    output io_pkg::io_data_t readdata_fixed
);

    logic in_window;   // inside one of the full windows
    logic is_half;     // one of the 16-bit ports

    // ----------------------------------------------------------
    // port map lookup
    // ----------------------------------------------------------
    always_comb begin
        in_window = 1'b0;
        is_half   = 1'b0;
        for (int i = 0; i < io_pkg::PORT_RANGE_COUNT; i++) begin
            if (bus_address >= io_pkg::PORT_RANGE_LO[i] &&
                bus_address <  io_pkg::PORT_RANGE_HI[i]) begin
                in_window = 1'b1;
            end
        end
        for (int i = 0; i < io_pkg::HALF_COUNT; i++) begin
            if (bus_address == io_pkg::HALF_PORTS[i]) begin
                is_half = 1'b1;
            end
        end
    end

    // half ports only decode the low two lanes
    assign unmapped = !(in_window || (is_half && (|bus_byteenable[1:0])));

    // read patch
    assign readdata_fixed = unmapped ? io_pkg::IO_ONES :
                            is_half  ? {16'hFFFF, bus_readdata[15:0]} :   // upper half floats
                                       bus_readdata;

endmodule

`default_nettype wire

/* logic/io_read_merge.sv */
`timescale 1ns/10ps
`default_nettype none

module io_read_merge (
    input  wire                   clk,
    input  wire                   rst,
    input  wire io_pkg::io_addr_t req_address,
    input  wire io_pkg::io_len_t  req_length,
    input  wire io_pkg::io_data_t readdata_fixed,
    input  wire                   load_first,
    input  wire                   load_second,

    output io_pkg::io_data_t read_data
);

    logic [1:0]       offset;
    logic [2:0]       first_cnt;     // bytes taken from the first word
    logic [2:0]       second_cnt;    // bytes still missing after it
    io_pkg::io_data_t first_word;
    io_pkg::io_data_t keep_mask;
    io_pkg::io_data_t take_mask;
    io_pkg::io_data_t second_word;

    assign offset     = req_address[1:0];
    assign first_cnt  = 3'd4 - {1'b0, offset};
    assign second_cnt = req_length - first_cnt;   // only meaningful when split

    // ----------------------------------------------------------
    // lane steering
    // ----------------------------------------------------------
    assign first_word = readdata_fixed >> {offset, 3'b000};   // request byte 0 to lane 0

    assign keep_mask   = ~(32'hFFFF_FFFF << {first_cnt, 3'b000});
    assign take_mask   = ~(32'hFFFF_FFFF << {second_cnt, 3'b000});
    assign second_word = (readdata_fixed & take_mask) << {first_cnt, 3'b000};

    always_ff @(posedge clk) begin
        if (rst) begin
            read_data <= '0;
        end else if (load_first) begin
            read_data <= first_word;
        end else if (load_second) begin
            read_data <= (read_data & keep_mask) | second_word;   // stitch halves
        end
    end

endmodule

`default_nettype wire

/* logic/io_bus_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module io_bus_ctrl (
    input  wire                   clk,
    input  wire                   rst,

    // core request
    input  wire                   read_do,
    input  wire io_pkg::io_addr_t read_address,
    input  wire io_pkg::io_len_t  read_length,
    input  wire                   write_do,
    input  wire io_pkg::io_addr_t write_address,
    input  wire io_pkg::io_len_t  write_length,
    input  wire                   cache_busy,
    output logic                  read_done,
    output logic                  write_done,

    // request seen by the splitter and the merge
    output io_pkg::io_addr_t      req_address,
    output io_pkg::io_len_t       req_length,

    input  wire io_pkg::io_be_t   be_first,
    input  wire io_pkg::io_be_t   be_second,
    input  wire io_pkg::io_data_t data_first,
    input  wire io_pkg::io_data_t data_second,
    input  wire                   two_phase,
    input  wire                   unmapped,

    // bus
    output io_pkg::io_addr_t      bus_address,
    output io_pkg::io_be_t        bus_byteenable,
    output logic                  bus_read,
    output logic                  bus_write,
    output io_pkg::io_data_t      bus_writedata,
    input  wire                   bus_waitrequest,
    input  wire                   bus_readdatavalid,

    output logic                  load_first,
    output logic                  load_second
);

    io_pkg::io_state_t state;
    io_pkg::io_addr_t  lat_address;   // request held for both phases
    io_pkg::io_len_t   lat_length;
    io_pkg::io_addr_t  next_address;
    logic              write_pick;
    logic              read_pick;
    logic              accept;
    logic              write_end;     // current write phase finishes
    logic              second_go;
    logic              read_reg;
    logic              write_reg;

    // ----------------------------------------------------------
    // request select, write first
    // ----------------------------------------------------------
    assign write_pick = write_do && !write_done && !cache_busy;
    assign read_pick  = !write_pick && read_do && !read_done && !cache_busy;
    assign accept     = (state == io_pkg::ST_IDLE) && (write_pick || read_pick);

    // idle shows the incoming request so phase one is ready at the accept edge
    assign req_address = (state != io_pkg::ST_IDLE) ? lat_address :
                         write_pick                 ? write_address : read_address;
    assign req_length  = (state != io_pkg::ST_IDLE) ? lat_length :
                         write_pick                 ? write_length : read_length;

    // unmapped phase finishes at once, no strobe
    assign write_end   = (state == io_pkg::ST_WRITE_1 || state == io_pkg::ST_WRITE_2) &&
                         (!bus_waitrequest || unmapped);
    assign load_first  = (state == io_pkg::ST_READ_1) && (bus_readdatavalid || unmapped);
    assign load_second = (state == io_pkg::ST_READ_2) && (bus_readdatavalid || unmapped);
    assign second_go   = two_phase &&
                         ((state == io_pkg::ST_WRITE_1 && write_end) || load_first);

    assign bus_read     = read_reg && !unmapped;
    assign bus_write    = write_reg && !unmapped;
    assign next_address = lat_address + 16'd4;   // following word

    // ----------------------------------------------------------
    // bus address, lanes and data per phase
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            lat_address    <= req_address;
            lat_length     <= req_length;
            bus_address    <= {req_address[15:2], 2'b00};
            bus_byteenable <= be_first;
            bus_writedata  <= data_first;
        end else if (second_go) begin
            bus_address    <= {next_address[15:2], 2'b00};
            bus_byteenable <= be_second;
            bus_writedata  <= data_second;
        end
    end

    // ----------------------------------------------------------
    // control FSM
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= io_pkg::ST_IDLE;
            read_reg   <= 1'b0;
            write_reg  <= 1'b0;
            read_done  <= 1'b0;
            write_done <= 1'b0;
        end else begin
            read_done  <= 1'b0;   // single-cycle pulses
            write_done <= 1'b0;
            case (state)
                io_pkg::ST_IDLE: begin
                    if (write_pick) begin
                        write_reg <= 1'b1;
                        state     <= io_pkg::ST_WRITE_1;
                    end else if (read_pick) begin
                        read_reg <= 1'b1;
                        state    <= io_pkg::ST_READ_1;
                    end
                end
                io_pkg::ST_WRITE_1, io_pkg::ST_WRITE_2: begin
                    if (write_end) begin
                        if (second_go) begin
                            state <= io_pkg::ST_WRITE_2;   // strobe stays up
                        end else begin
                            write_reg  <= 1'b0;
                            write_done <= 1'b1;
                            state      <= io_pkg::ST_IDLE;
                        end
                    end
                end
                io_pkg::ST_READ_1, io_pkg::ST_READ_2: begin
                    if (!bus_waitrequest || unmapped) begin
                        read_reg <= 1'b0;   // command taken, wait for data
                    end
                    if (second_go) begin
                        read_reg <= 1'b1;
                        state    <= io_pkg::ST_READ_2;
                    end else if (load_first || load_second) begin
                        read_reg  <= 1'b0;
                        read_done <= 1'b1;
                        state     <= io_pkg::ST_IDLE;
                    end
                end
                default: state <= io_pkg::ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/io_bridge.sv */
`timescale 1ns/10ps
`default_nettype none

module io_bridge (
    input  wire                   clk,
    input  wire                   rst,

    // core side
    input  wire                   read_do,
    input  wire io_pkg::io_addr_t read_address,
    input  wire io_pkg::io_len_t  read_length,
    output io_pkg::io_data_t      read_data,
    output logic                  read_done,
    input  wire                   write_do,
    input  wire io_pkg::io_addr_t write_address,
    input  wire io_pkg::io_len_t  write_length,
    input  wire io_pkg::io_data_t write_data,
    output logic                  write_done,
    input  wire                   cache_busy,

    // Avalon-MM side
    output io_pkg::io_addr_t      bus_address,
    output io_pkg::io_be_t        bus_byteenable,
    output logic                  bus_read,
    output logic                  bus_write,
    output io_pkg::io_data_t      bus_writedata,
    input  wire                   bus_waitrequest,
    input  wire                   bus_readdatavalid,
    input  wire io_pkg::io_data_t bus_readdata
);

    io_pkg::io_addr_t req_address;
    io_pkg::io_len_t  req_length;
    io_pkg::io_be_t   be_first;
    io_pkg::io_be_t   be_second;
    io_pkg::io_data_t data_first;
    io_pkg::io_data_t data_second;
    io_pkg::io_data_t readdata_fixed;   // after port map patching
    logic             two_phase;
    logic             unmapped;
    logic             load_first;
    logic             load_second;

    // ----------------------------------------------------------
    // control
    // ----------------------------------------------------------
    io_bus_ctrl u_io_bus_ctrl (
        .clk, .rst,
        .read_do, .read_address, .read_length,
        .write_do, .write_address, .write_length,
        .cache_busy, .read_done, .write_done,
        .req_address, .req_length,
        .be_first, .be_second, .data_first, .data_second, .two_phase,
        .unmapped,
        .bus_address, .bus_byteenable, .bus_read, .bus_write, .bus_writedata,
        .bus_waitrequest, .bus_readdatavalid,
        .load_first, .load_second
    );

    // ----------------------------------------------------------
    // datapath
    // ----------------------------------------------------------
    io_lane_split u_io_lane_split (
        .req_address, .req_length, .write_data,
        .be_first, .be_second, .data_first, .data_second, .two_phase
    );

    io_port_decode u_io_port_decode (
        .bus_address, .bus_byteenable, .bus_readdata,
        .unmapped, .readdata_fixed
    );

    io_read_merge u_io_read_merge (
        .clk, .rst, .req_address, .req_length, .readdata_fixed,
        .load_first, .load_second, .read_data
    );

endmodule

`default_nettype wire

/* sim/io_device_model.sv */
`timescale 1ns/10ps
`default_nettype none

module io_device_model (
    input  wire                   clk,
    input  wire                   rst,
    input  wire io_pkg::io_addr_t bus_address,
    input  wire io_pkg::io_be_t   bus_byteenable,
    input  wire                   bus_read,
    input  wire                   bus_write,
    input  wire io_pkg::io_data_t bus_writedata,
    output logic                  bus_waitrequest,
    output logic                  bus_readdatavalid,
    output io_pkg::io_data_t      bus_readdata,
    output int                    bad_strobes      // strobes seen on unmapped ports
);

    logic [7:0] mem [0:65535];   // one byte per port
    int         seed = 32'h3a60;
    logic [1:0] wait_left;       // wait states still owed to this command
    logic [1:0] rdv_left;        // cycles until readdatavalid
    logic       rd_pending;

    // port map as the devices see it
    function automatic logic port_mapped(input io_pkg::io_addr_t word,
                                         input io_pkg::io_be_t be);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < io_pkg::PORT_RANGE_COUNT; i++) begin
            if (word >= io_pkg::PORT_RANGE_LO[i] && word < io_pkg::PORT_RANGE_HI[i]) begin
                hit = 1'b1;
            end
        end
        for (int i = 0; i < io_pkg::HALF_COUNT; i++) begin
            if (word == io_pkg::HALF_PORTS[i] && be[1:0] != 2'b00) begin
                hit = 1'b1;   // 16-bit port, low lanes only
            end
        end
        return hit;
    endfunction

    assign bus_waitrequest = (bus_read || bus_write) && wait_left != 2'd0;

    // ----------------------------------------------------------
    // command acceptance and read return
    // ----------------------------------------------------------
    always @(posedge clk) begin : device_seq
        logic [1:0] delay;
        if (rst) begin
            for (int a = 0; a < 65536; a++) begin
                mem[16'(a)] = 8'(a) ^ 8'(a >> 8) ^ 8'h5A;   // pattern over the whole address
            end
            wait_left         <= 2'd0;
            rdv_left          <= 2'd0;
            rd_pending        <= 1'b0;
            bus_readdatavalid <= 1'b0;
            bus_readdata      <= '0;
            bad_strobes       <= 0;
        end else begin
            bus_readdatavalid <= 1'b0;
            if (bus_read || bus_write) begin
                assert (port_mapped(bus_address, bus_byteenable)) else begin
                    $display("device model: bus strobe seen on unmapped port %h at %0t",
                             bus_address, $time);
                    bad_strobes <= bad_strobes + 1;
                end
            end
            if ((bus_read || bus_write) && wait_left != 2'd0) begin
                wait_left <= wait_left - 2'd1;   // stall this cycle
            end else if (bus_write) begin
                for (int l = 0; l < 4; l++) begin
                    if (bus_byteenable[l]) begin
                        mem[{bus_address[15:2], 2'(l)}] = bus_writedata[8*l +: 8];
                    end
                end
                wait_left <= 2'($random(seed));   // for the next command
            end else if (bus_read) begin
                for (int l = 0; l < 4; l++) begin
                    bus_readdata[8*l +: 8] <= mem[{bus_address[15:2], 2'(l)}];
                end
                delay = 2'($random(seed));
                bus_readdatavalid <= (delay == 2'd0);
                rd_pending        <= (delay != 2'd0);
                rdv_left          <= delay - 2'd1;
                wait_left         <= 2'($random(seed));
            end else if (rd_pending) begin
                if (rdv_left == 2'd0) begin
                    bus_readdatavalid <= 1'b1;   // data held since acceptance
                    rd_pending        <= 1'b0;
                end else begin
                    rdv_left <= rdv_left - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* sim/tb_io_bridge.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_io_bridge;

    localparam int LIMIT_CYCLES = 10000;   // 500 transfers x 2 phases x 10 cycles

    logic             clk;
    logic             rst;
    logic             read_do;
    io_pkg::io_addr_t read_address;
    io_pkg::io_len_t  read_length;
    io_pkg::io_data_t read_data;
    logic             read_done;
    logic             write_do;
    io_pkg::io_addr_t write_address;
    io_pkg::io_len_t  write_length;
    io_pkg::io_data_t write_data;
    logic             write_done;
    logic             cache_busy;
    io_pkg::io_addr_t bus_address;
    io_pkg::io_be_t   bus_byteenable;
    logic             bus_read;
    logic             bus_write;
    io_pkg::io_data_t bus_writedata;
    logic             bus_waitrequest;
    logic             bus_readdatavalid;
    io_pkg::io_data_t bus_readdata;
    int               bad_strobes;

    int               seed = 32'h3a60;
    int               busy_seed = 32'h3a60;   // own stream for the stall process
    int               errors = 0;
    logic [7:0]       shadow [0:65535];   // what the ports should hold
    io_pkg::io_data_t exp_q [$];          // expected read words in issue order
    io_pkg::io_data_t mask_q [$];         // requested bytes of each read
    logic             write_q [$];        // writes still waiting for done

    io_bridge u_io_bridge (
        .clk, .rst,
        .read_do, .read_address, .read_length, .read_data, .read_done,
        .write_do, .write_address, .write_length, .write_data, .write_done,
        .cache_busy,
        .bus_address, .bus_byteenable, .bus_read, .bus_write, .bus_writedata,
        .bus_waitrequest, .bus_readdatavalid, .bus_readdata
    );

    io_device_model u_io_device_model (
        .clk, .rst,
        .bus_address, .bus_byteenable, .bus_read, .bus_write, .bus_writedata,
        .bus_waitrequest, .bus_readdatavalid, .bus_readdata,
        .bad_strobes
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ----------------------------------------------------------
    // reference model
    // ----------------------------------------------------------
    function automatic logic is_half(input io_pkg::io_addr_t word);
        return word == 16'h0020 || word == 16'h0070 || word == 16'h00A0;
    endfunction

    // does the bus phase carrying request byte i reach a device
    function automatic logic byte_reaches(input io_pkg::io_addr_t addr,
                                          input io_pkg::io_len_t len, input int i);
        io_pkg::io_addr_t a;
        io_pkg::io_addr_t b;
        io_pkg::io_addr_t word;
        logic [3:0]       be;
        logic             hit;
        a    = addr + 16'(i);
        word = {a[15:2], 2'b00};
        be   = 4'b0000;
        hit  = 1'b0;
        for (int k = 0; k < int'(len); k++) begin
            b = addr + 16'(k);
            if (b[15:2] == a[15:2]) begin
                be[b[1:0]] = 1'b1;   // lanes of this phase
            end
        end
        for (int w = 0; w < io_pkg::PORT_RANGE_COUNT; w++) begin
            if (word >= io_pkg::PORT_RANGE_LO[w] && word < io_pkg::PORT_RANGE_HI[w]) begin
                hit = 1'b1;
            end
        end
        if (is_half(word) && be[1:0] != 2'b00) begin
            hit = 1'b1;
        end
        return hit;
    endfunction

    function automatic io_pkg::io_data_t io_expect(input io_pkg::io_addr_t addr,
                                                   input io_pkg::io_len_t len);
        io_pkg::io_data_t r;
        io_pkg::io_addr_t a;
        r = '0;
        for (int i = 0; i < int'(len); i++) begin
            a = addr + 16'(i);
            if (!byte_reaches(addr, len, i) || (is_half({a[15:2], 2'b00}) && a[1])) begin
                r[8*i +: 8] = 8'hFF;   // nothing drives these lanes
            end else begin
                r[8*i +: 8] = shadow[a];
            end
        end
        return r;
    endfunction

    // ----------------------------------------------------------
    // core side requests
    // ----------------------------------------------------------
    task automatic issue_write(input io_pkg::io_addr_t addr, input io_pkg::io_len_t len,
                               input io_pkg::io_data_t data);
        @(posedge clk);
        for (int i = 0; i < int'(len); i++) begin
            if (byte_reaches(addr, len, i)) begin
                shadow[addr + 16'(i)] = data[8*i +: 8];
            end
        end
        write_q.push_back(1'b1);
        write_do      <= 1'b1;
        write_address <= addr;
        write_length  <= len;
        write_data    <= data;
        do @(posedge clk); while (!write_done);
        write_do <= 1'b0;
    endtask

    task automatic issue_read(input io_pkg::io_addr_t addr, input io_pkg::io_len_t len);
        @(posedge clk);
        exp_q.push_back(io_expect(addr, len));
        mask_q.push_back(~(32'hFFFF_FFFF << {len, 3'b000}));
        read_do      <= 1'b1;
        read_address <= addr;
        read_length  <= len;
        do @(posedge clk); while (!read_done);
        read_do <= 1'b0;
    endtask

    task automatic random_request();
        io_pkg::io_addr_t addr;
        io_pkg::io_len_t  len;
        logic [31:0]      r;
        int               w;
        r   = $random(seed);
        len = r[1] ? 3'd4 : (r[0] ? 3'd2 : 3'd1);
        if (r[3:2] == 2'b00) begin
            addr = 16'($random(seed)) & 16'h0FFF;   // mostly unmapped
        end else if (r[3:2] == 2'b01) begin
            addr = (r[7] ? 16'h0070 : 16'h00A0) + {14'd0, r[6:5]};
        end else begin
            w    = int'($unsigned($random(seed)) % 32'(io_pkg::PORT_RANGE_COUNT));
            addr = io_pkg::PORT_RANGE_LO[w] + 16'($unsigned($random(seed)) %
                   32'(io_pkg::PORT_RANGE_HI[w] - io_pkg::PORT_RANGE_LO[w]));
        end
        if (r[4]) begin
            issue_write(addr, len, $random(seed));
        end else begin
            issue_read(addr, len);
        end
    endtask

    // cache stalls of random length
    initial begin
        cache_busy <= 1'b0;
        forever begin
            @(posedge clk);
            cache_busy <= (3'($random(busy_seed)) < 3'd2);
        end
    end

    // ----------------------------------------------------------
    // read compare and done accounting
    // ----------------------------------------------------------
    always @(posedge clk) begin : compare
        io_pkg::io_data_t exp_word;
        io_pkg::io_data_t mask;
        if (read_done) begin
            assert (exp_q.size() > 0) else begin
                $display("read_done pulsed at %0t with no read outstanding", $time);
                errors++;
            end
            if (exp_q.size() > 0) begin
                exp_word = exp_q.pop_front();
                mask     = mask_q.pop_front();
                assert ((read_data & mask) == exp_word) else begin
                    $display("Error: %0t read of port %h gave %h, expected %h",
                             $time, read_address, read_data & mask, exp_word);
                    errors++;
                end
            end
        end
        if (write_done) begin
            assert (write_q.size() > 0) else begin
                $display("write_done pulsed at %0t with no write outstanding", $time);
                errors++;
            end
            if (write_q.size() > 0) begin
                void'(write_q.pop_front());
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < LIMIT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("bridge hang: run still busy after %0d cycles", cycles);
        $display("TEST FAIL");
        $finish;
    end

    // ----------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------
    initial begin : stimulus
        rst           <= 1'b1;
        read_do       <= 1'b0;
        read_address  <= '0;
        read_length   <= 3'd1;
        write_do      <= 1'b0;
        write_address <= '0;
        write_length  <= 3'd1;
        write_data    <= '0;
        for (int a = 0; a < 65536; a++) begin
            shadow[16'(a)] = 8'(a) ^ 8'(a >> 8) ^ 8'h5A;   // same fill as the device
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // aligned
        issue_write(16'h0040, 3'd4, 32'h1234_5678);
        issue_read(16'h0040, 3'd4);
        issue_write(16'h0062, 3'd2, 32'h0000_BEEF);
        issue_read(16'h0062, 3'd2);
        issue_write(16'h0003, 3'd1, 32'h0000_00A5);
        issue_read(16'h0003, 3'd1);
        issue_read(16'h0000, 3'd4);

        // split over two words
        issue_write(16'h0083, 3'd2, 32'h0000_C3D4);
        issue_read(16'h0083, 3'd2);
        for (int off = 1; off < 4; off++) begin
            issue_write(16'h00C4 + 16'(off), 3'd4, 32'hA0B1_C2D3 ^ 32'(off));
            issue_read(16'h00C4 + 16'(off), 3'd4);
        end

        // unmapped as a whole and as half of a split
        issue_write(16'h0300, 3'd4, 32'hDEAD_BEEF);
        issue_read(16'h0300, 3'd4);
        issue_write(16'h000E, 3'd4, 32'h7766_5544);
        issue_read(16'h000E, 3'd4);

        // 16-bit ports
        issue_write(16'h0070, 3'd4, 32'h55AA_1234);
        issue_read(16'h0070, 3'd4);
        issue_read(16'h0072, 3'd2);   // upper lanes only
        issue_write(16'h00A2, 3'd2, 32'h0000_9999);
        issue_read(16'h00A0, 3'd4);
        issue_write(16'h009F, 3'd4, 32'h0F1E_2D3C);
        issue_read(16'h009F, 3'd4);

        repeat (400) random_request();
        repeat (4) @(posedge clk);

        $display("run finished: %0d data or handshake errors, %0d unmapped strobes",
                 errors, bad_strobes);
        if (errors == 0 && bad_strobes == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
logic/io_pkg.sv
logic/io_lane_split.sv
logic/io_port_decode.sv
logic/io_read_merge.sv
logic/io_bus_ctrl.sv
logic/io_bridge.sv
sim/io_device_model.sv
sim/tb_io_bridge.sv

/* Makefile */
# Verilator build and run of the I/O bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_io_bridge
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "TEST PASS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
